//--- hdl/imem_pkg.sv
`default_nettype none

package imem_pkg;

	// instruction memory geometry
	localparam int imem_addr_width = 4;
	localparam int imem_depth = 2 ** imem_addr_width;

	typedef logic [imem_addr_width-1:0] pc_t;
	typedef logic [31:0] inst_t;

	// power-up image
	localparam inst_t boot_word_0 = 32'hec000000;
	localparam inst_t boot_word_1 = 32'hf0000000;
	localparam inst_t boot_word_fill = 32'h0c000000;

	// serial timing, kept short for simulation
	localparam int clks_per_bit = 8;
	localparam int half_bit_clks = clks_per_bit / 2;
	localparam int baud_cnt_width = $clog2(clks_per_bit);
	localparam int rx_data_bits = 8;

	typedef logic [baud_cnt_width-1:0] baud_cnt_t;
	typedef logic [$clog2(rx_data_bits)-1:0] bit_idx_t;
	typedef logic [rx_data_bits-1:0] rx_data_t;

	// one received byte, data meaningful only while valid
	typedef struct packed {
		rx_data_t data;
		logic valid;
	} rx_byte_t;

	// registered fetch result
	typedef struct packed {
		inst_t inst;
		logic distinct;
	} fetch_t;

	typedef enum logic [2:0] {
		load_idle,
		load_byte0,
		load_byte1,
		load_byte2,
		load_byte3,
		load_write
	} load_state_e;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_e;

endpackage

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx import imem_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx,
	output rx_byte_t rx_byte,
	output logic frame_error
);

	// line synchronizer and edge history
	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic rx_fall;

	rx_state_e rx_state;
	baud_cnt_t baud_cnt;
	bit_idx_t bit_idx;
	rx_data_t shift_reg;
	logic valid_q;
	logic frame_error_q;

	logic half_done;
	logic bit_done;
	logic last_bit;
	logic data_sample;

	// idle line is high, so the flops come out of reset high
	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	// start condition is a high to low transition
	assign rx_fall = rx_last && !rx_sync;

	assign half_done = (baud_cnt == baud_cnt_t'(half_bit_clks - 1));
	assign bit_done = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));
	assign last_bit = (bit_idx == bit_idx_t'(rx_data_bits - 1));
	assign data_sample = (rx_state == rx_data) && bit_done;

	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_state <= rx_idle;
			baud_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
			frame_error_q <= 1'b0;
		end else begin
			// strobes last one cycle
			valid_q <= 1'b0;
			frame_error_q <= 1'b0;
			case (rx_state)
				rx_idle: begin
					baud_cnt <= '0;
					if (rx_fall) begin
						rx_state <= rx_start;
					end
				end
				rx_start: begin
					if (half_done) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						// start bit gone high again, treat as glitch
						if (rx_sync) begin
							rx_state <= rx_idle;
						end else begin
							rx_state <= rx_data;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (bit_done) begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (last_bit) begin
							rx_state <= rx_stop;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (bit_done) begin
						baud_cnt <= '0;
						rx_state <= rx_idle;
						if (rx_sync) begin
							valid_q <= 1'b1;
						end else begin
							frame_error_q <= 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: begin
					rx_state <= rx_idle;
				end
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge CLK) begin
		if (data_sample) begin
			shift_reg <= {rx_sync, shift_reg[rx_data_bits-1:1]};
		end
	end

	// shift_reg is stable from the stop bit until the next data bit
	assign rx_byte.data = shift_reg;
	assign rx_byte.valid = valid_q;
	assign frame_error = frame_error_q;

endmodule

`default_nettype wire

//--- hdl/inst_memory.sv
`timescale 1ns/10ps
`default_nettype none

module inst_memory import imem_pkg::*; (
	input logic CLK,
	input logic reset,
	input pc_t pc,
	input rx_byte_t loader_byte,
	input logic loader_enable,
	output fetch_t fetch
);

	// word storage, boot image at power-up
	inst_t mem [imem_depth] = '{
		0: boot_word_0,
		1: boot_word_1,
		default: boot_word_fill
	};

	// fetch side
	inst_t inst_q;
	logic distinct_q;
	pc_t pc_prev;
	logic pc_seen;

	// loader side
	load_state_e load_state;
	load_state_e load_state_next;
	pc_t load_index;
	inst_t load_buf;
	logic load_take;
	logic load_commit;

	// a byte only counts while loading is enabled
	assign load_take = loader_enable && loader_byte.valid;
	assign load_commit = (load_state == load_write);

	// registered read, plus the loader write port
	always_ff @(posedge CLK) begin
		if (load_commit) begin
			mem[load_index] <= load_buf;
		end
		inst_q <= mem[pc];
	end

	// last sampled pc, compared on the next edge
	always_ff @(posedge CLK) begin
		pc_prev <= pc;
	end

	// first fetch after reset always counts as a new pc
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc_seen <= 1'b0;
			distinct_q <= 1'b1;
		end else begin
			pc_seen <= 1'b1;
			distinct_q <= !pc_seen || (pc != pc_prev);
		end
	end

	assign fetch.inst = inst_q;
	assign fetch.distinct = distinct_q;

	// next state of the byte-packing loader
	always_comb begin
		load_state_next = load_state;
		if (!loader_enable) begin
			load_state_next = load_idle;
		end else begin
			case (load_state)
				load_idle: begin
					load_state_next = load_byte0;
				end
				load_byte0: begin
					if (load_take) begin
						load_state_next = load_byte1;
					end
				end
				load_byte1: begin
					if (load_take) begin
						load_state_next = load_byte2;
					end
				end
				load_byte2: begin
					if (load_take) begin
						load_state_next = load_byte3;
					end
				end
				load_byte3: begin
					if (load_take) begin
						load_state_next = load_write;
					end
				end
				load_write: begin
					// straight on to the next word
					load_state_next = load_byte0;
				end
				default: begin
					load_state_next = load_idle;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			load_state <= load_idle;
		end else begin
			load_state <= load_state_next;
		end
	end

	// index restarts whenever loading is switched off
	always_ff @(posedge CLK) begin
		if (reset || !loader_enable) begin
			load_index <= '0;
		end else if (load_commit) begin
			load_index <= load_index + 1'b1;
		end
	end

	// little endian packing, byte 0 into bits 7:0
	always_ff @(posedge CLK) begin
		if (load_take) begin
			case (load_state)
				load_byte0: begin
					load_buf[7:0] <= loader_byte.data;
				end
				load_byte1: begin
					load_buf[15:8] <= loader_byte.data;
				end
				load_byte2: begin
					load_buf[23:16] <= loader_byte.data;
				end
				load_byte3: begin
					load_buf[31:24] <= loader_byte.data;
				end
				default: begin
					load_buf <= load_buf;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/imem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module imem_subsystem import imem_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx,
	input logic loader_enable,
	input pc_t pc,
	output fetch_t fetch,
	output logic frame_error
);

	// received bytes, one-cycle valid strobe
	rx_byte_t rx_byte;

	// host serial link
	uart_rx i_uart_rx (
		.CLK(CLK),
		.reset(reset),
		.rx(rx),
		.rx_byte(rx_byte),
		.frame_error(frame_error)
	);

	// instruction store and loader
	inst_memory i_inst_memory (
		.CLK(CLK),
		.reset(reset),
		.pc(pc),
		.loader_byte(rx_byte),
		.loader_enable(loader_enable),
		.fetch(fetch)
	);

endmodule

`default_nettype wire

//--- testbench/inst_memory_sva.sv
`timescale 1ns/10ps
`default_nettype none

module inst_memory_sva import imem_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic loader_enable,
	input rx_byte_t loader_byte,
	input fetch_t fetch,
	input load_state_e load_state,
	input pc_t load_index
);

	int assert_fails = 0;

	// loading off means idle at index 0 on the next edge
	loader_off_idle: assert property (@(posedge CLK) disable iff (reset)
		!loader_enable |=> (load_state == load_idle) && (load_index == '0))
	else begin
		assert_fails++;
		$error("loader not idle at index 0 after loader_enable was low");
	end

	// byte strobe is a single cycle
	valid_one_cycle: assert property (@(posedge CLK) disable iff (reset)
		loader_byte.valid |=> !loader_byte.valid)
	else begin
		assert_fails++;
		$error("loader_byte.valid high for two cycles in a row");
	end

	reset_distinct: assert property (@(posedge CLK)
		$fell(reset) |=> fetch.distinct)
	else begin
		assert_fails++;
		$error("fetch.distinct low in the cycle after reset release");
	end

endmodule

`default_nettype wire

//--- testbench/tb_imem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_imem_subsystem import imem_pkg::*; ();

	typedef enum logic [1:0] {
		op_load,
		op_fetch,
		op_abort,
		op_bad_frame
	} op_e;

	typedef struct packed {
		op_e op;
		pc_t addr;
		inst_t word;
	} step_t;

	localparam int clk_half_period = 4;
	localparam int reset_cycles = 10;
	localparam int hold_cycles = 3;
	localparam int frame_wait_cycles = 4 * clks_per_bit;

	logic CLK = 1'b0;
	logic reset;
	logic rx;
	logic loader_enable;
	pc_t pc;
	fetch_t fetch;
	logic frame_error;

	step_t steps[$];
	inst_t exp_mem [imem_depth];
	pc_t exp_index;
	pc_t last_pc;
	inst_t rng_state;
	int frame_error_count = 0;

	always #clk_half_period CLK = ~CLK;

	imem_subsystem i_imem_subsystem (
		.CLK(CLK),
		.reset(reset),
		.rx(rx),
		.loader_enable(loader_enable),
		.pc(pc),
		.fetch(fetch),
		.frame_error(frame_error)
	);

	bind inst_memory inst_memory_sva i_inst_memory_sva (
		.CLK(CLK),
		.reset(reset),
		.loader_enable(loader_enable),
		.loader_byte(loader_byte),
		.fetch(fetch),
		.load_state(load_state),
		.load_index(load_index)
	);

	// frame_error pulses counted as they happen
	always @(posedge CLK) begin
		if (frame_error === 1'b1) begin
			frame_error_count <= frame_error_count + 1;
		end
	end

	function automatic inst_t xorshift32(input inst_t s);
		inst_t x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic inst_t next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic fetch_t expect_fetch(input inst_t inst, input logic distinct);
		fetch_t f;
		f.inst = inst;
		f.distinct = distinct;
		return f;
	endfunction

	task automatic fail_run(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_fetch(input fetch_t got, input fetch_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("%s: inst %h distinct %b, expected inst %h distinct %b",
				what, got.inst, got.distinct, exp.inst, exp.distinct));
		end
	endtask

	task automatic check_frame_error(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("%s: frame_error %b, expected %b", what, got, exp));
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic drive_point();
		@(posedge CLK);
		#1;
	endtask

	task automatic drive_bit(input logic b);
		rx = b;
		repeat (clks_per_bit) drive_point();
	endtask

	// 8N1 frame plus one idle bit so a low stop bit is followed by a clean edge
	task automatic send_byte(input logic [7:0] data, input logic stop_ok);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(stop_ok);
		drive_bit(1'b1);
	endtask

	task automatic start_load();
		if (!loader_enable) begin
			loader_enable = 1'b1;
			exp_index = '0;
			drive_point();
			drive_point();
		end
	endtask

	task automatic stop_load();
		if (loader_enable) begin
			loader_enable = 1'b0;
			exp_index = '0;
			drive_point();
		end
	endtask

	task automatic do_load(input step_t s);
		int snap;
		snap = frame_error_count;
		start_load();
		for (int b = 0; b < 4; b++) begin
			send_byte(s.word[8*b +: 8], 1'b1);
		end
		check_frame_error(frame_error_count != snap, 1'b0, "good bytes of a load");
		exp_mem[exp_index] = s.word;
		exp_index = exp_index + 1'b1;
	endtask

	// two bytes in and then loading switched off
	task automatic do_abort(input step_t s);
		start_load();
		send_byte(s.word[7:0], 1'b1);
		send_byte(s.word[15:8], 1'b1);
		stop_load();
	endtask

	task automatic do_bad_frame(input step_t s);
		int snap;
		int waited;
		snap = frame_error_count;
		waited = 0;
		start_load();
		send_byte(s.word[7:0], 1'b0);
		while (frame_error_count == snap && waited < frame_wait_cycles) begin
			drive_point();
			waited++;
		end
		if (frame_error_count == snap) begin
			fail_run("no frame_error pulse after a byte with a low stop bit");
		end
		if (frame_error_count != snap + 1) begin
			fail_run("frame_error pulsed more than once for one bad byte");
		end
		check_frame_error(frame_error, 1'b0, "frame_error after its pulse");
	endtask

	task automatic do_fetch(input step_t s);
		fetch_t exp;
		string what;
		stop_load();
		exp = expect_fetch(exp_mem[s.addr], s.addr != last_pc);
		what = $sformatf("fetch at address %0d", s.addr);
		pc = s.addr;
		// old word stays until the new pc is sampled
		@(negedge CLK);
		check_fetch(fetch, expect_fetch(exp_mem[last_pc], 1'b0), what);
		last_pc = s.addr;
		@(posedge CLK);
		@(negedge CLK);
		check_fetch(fetch, exp, what);
		// distinct drops while pc is held
		repeat (hold_cycles) begin
			@(negedge CLK);
			check_fetch(fetch, expect_fetch(exp_mem[s.addr], 1'b0), what);
		end
		drive_point();
	endtask

	task automatic add_step(input op_e op, input int addr, input inst_t word);
		step_t s;
		s.op = op;
		s.addr = pc_t'(addr);
		s.word = word;
		steps.push_back(s);
	endtask

	task automatic build_table();
		// boot image with a repeated address that keeps distinct low
		add_step(op_fetch, 0, '0);
		add_step(op_fetch, 1, '0);
		add_step(op_fetch, 1, '0);
		add_step(op_fetch, 7, '0);
		add_step(op_fetch, 15, '0);
		add_step(op_fetch, 3, '0);
		// random words from address 0 and a full read back
		for (int i = 0; i < 6; i++) begin
			add_step(op_load, 0, next_random());
		end
		for (int i = 0; i < imem_depth; i++) begin
			add_step(op_fetch, i, '0);
		end
		// abort inside the third word and restart at 0
		add_step(op_load, 0, next_random());
		add_step(op_load, 0, next_random());
		add_step(op_abort, 0, next_random());
		add_step(op_load, 0, next_random());
		for (int i = 0; i < 4; i++) begin
			add_step(op_fetch, i, '0);
		end
		// bad frame between two words
		add_step(op_load, 0, next_random());
		add_step(op_bad_frame, 0, next_random());
		add_step(op_load, 0, next_random());
		for (int i = 0; i < 3; i++) begin
			add_step(op_fetch, i, '0);
		end
	endtask

	initial begin
		reset = 1'b1;
		rx = 1'b1;
		loader_enable = 1'b0;
		pc = '0;
		rng_state = 32'h1fd8ecdd;
		exp_index = '0;
		last_pc = '0;
		for (int i = 0; i < imem_depth; i++) begin
			exp_mem[i] = (i == 0) ? boot_word_0 : (i == 1) ? boot_word_1 : boot_word_fill;
		end
		build_table();

		repeat (reset_cycles) @(posedge CLK);
		#1;
		reset = 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		check_fetch(fetch, expect_fetch(boot_word_0, 1'b1), "first fetch after reset");
		drive_point();

		foreach (steps[i]) begin
			case (steps[i].op)
				op_load: do_load(steps[i]);
				op_fetch: do_fetch(steps[i]);
				op_abort: do_abort(steps[i]);
				default: do_bad_frame(steps[i]);
			endcase
		end

		if (i_imem_subsystem.i_inst_memory.i_inst_memory_sva.assert_fails != 0) begin
			fail_run("concurrent assertions in inst_memory failed during the run");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/imem_pkg.sv
hdl/uart_rx.sv
hdl/inst_memory.sv
hdl/imem_subsystem.sv
testbench/inst_memory_sva.sv
testbench/tb_imem_subsystem.sv

//--- Bender.yml
package:
  name: imem_subsystem

sources:
  - files:
      - hdl/imem_pkg.sv
      - hdl/uart_rx.sv
      - hdl/inst_memory.sv
      - hdl/imem_subsystem.sv
  - target: test
    files:
      - testbench/inst_memory_sva.sv
      - testbench/tb_imem_subsystem.sv
